/* compile.f */
src/core_pkg.sv
src/issue_if.sv
src/result_if.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/int_core.sv
sim/int_core_assert.sv
sim/int_core_tb.sv

/* Makefile */
# Verilator build and run for the integer core testbench

VERILATOR ?= verilator
TOP       ?= int_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= $(BUILD_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/int_core_tb.sv */
`timescale 1ns/1ps
//####################
// testbench for the integer core with random traffic against a reference model
//####################
module int_core_tb;
  import core_pkg::*;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic [xlen-1:0]       in_pc;
  inst_u                 in_inst;
  logic                  in_allowin;
  logic                  redirect_valid;
  logic [xlen-1:0]       redirect_pc;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  // reference model state
  logic [xlen-1:0] mirror [32];
  logic [68:0]     exp_q [$];
  logic            exp_redir;
  logic [xlen-1:0] exp_redir_pc;
  logic [xlen-1:0] pc;

  int_core i_int_core (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic inst_u enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                  input logic [4:0] rs1, input logic [4:0] rd,
                                  input logic [11:0] imm);
    inst_u w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = opc;
    return w;
  endfunction

  function automatic inst_u enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [6:0] opc);
    inst_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = opc;
    return w;
  endfunction

  // legal ALU op on x0..x7 in dword or word form
  function automatic inst_u rand_alu();
    inst_u       w;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    int          kind;
    kind = $urandom_range(0, 3);
    f3   = 3'($urandom);
    alt  = 1'($urandom);
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    imm  = 12'($urandom);
    // word forms only for add/sub, sll and the right shifts
    if (kind == 1 || kind == 3) begin
      f3 = f3[0] ? 3'b101 : {2'b00, f3[1]};
    end
    if (f3 != 3'b000 && f3 != 3'b101) begin
      alt = 1'b0;
    end
    case (kind)
      0: w = enc_i(op_imm, f3, rs1, rd, (f3 == 3'b001 || f3 == 3'b101) ?
                   {1'b0, alt, 4'h0, imm[5:0]} : imm);
      1: w = enc_i(op_imm_32, f3, rs1, rd, (f3 == 3'b000) ? imm :
                   {1'b0, alt, 5'h00, imm[4:0]});
      2: w = enc_r({1'b0, alt, 5'h00}, rs2, rs1, f3, rd, op_op);
      default: w = enc_r({1'b0, alt, 5'h00}, rs2, rs1, f3, rd, op_op_32);
    endcase
    return w;
  endfunction

  // ISA semantics of one accepted instruction
  function automatic void model_step(input logic [63:0] at_pc, input inst_u w);
    logic [31:0] iw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] target;
    logic [31:0] rw;
    logic        alt;
    logic        wr;
    logic        take;
    iw     = w;
    a      = mirror[iw[19:15]];
    b      = mirror[iw[24:20]];
    alt    = iw[30];
    wr     = 1'b1;
    take   = 1'b0;
    res    = '0;
    rw     = '0;
    target = '0;
    if (iw[6:0] == op_imm || iw[6:0] == op_imm_32) begin
      b   = {{52{iw[31]}}, iw[31:20]};
      alt = alt && (iw[14:12] == 3'b101);
    end
    case (iw[6:0])
      op_imm, op_op: begin
        case (iw[14:12])
          3'b000:  res = alt ? a - b : a + b;
          3'b001:  res = a << b[5:0];
          3'b010:  res = 64'($signed(a) < $signed(b));
          3'b011:  res = 64'(a < b);
          3'b100:  res = a ^ b;
          3'b101:  res = alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      op_imm_32, op_op_32: begin
        case (iw[14:12])
          3'b000:  rw = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
          3'b001:  rw = a[31:0] << b[4:0];
          default: rw = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
        endcase
        res = {{32{rw[31]}}, rw};
      end
      op_lui:   res = {{32{iw[31]}}, iw[31:12], 12'h000};
      op_auipc: res = at_pc + {{32{iw[31]}}, iw[31:12], 12'h000};
      op_branch: begin
        wr     = 1'b0;
        target = at_pc + {{52{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
        case (iw[14:12])
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          3'b110:  take = (a < b);
          default: take = (a >= b);
        endcase
      end
      op_jal: begin
        take   = 1'b1;
        res    = at_pc + 64'd4;
        target = at_pc + {{44{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
      end
      op_jalr: begin
        take   = 1'b1;
        res    = at_pc + 64'd4;
        target = (a + {{52{iw[31]}}, iw[31:20]}) & ~64'h1;
      end
      default: wr = 1'b0;
    endcase
    if (wr && iw[11:7] != 5'd0) begin
      mirror[iw[11:7]] = res;
      exp_q.push_back({iw[11:7], res});
    end
    exp_redir    = take;
    exp_redir_pc = target;
  endfunction

  // hold one instruction until it is accepted
  task automatic send(input inst_u word);
    int waits;
    in_valid <= 1'b1;
    in_pc    <= pc;
    in_inst  <= word;
    waits = 0;
    @(negedge clk);
    while (!in_allowin) begin
      waits++;
      if (waits > 50) begin
        abort_run("in_allowin stayed low too long");
      end
      @(negedge clk);
    end
    @(posedge clk);
    pc = pc + 64'd4;
    in_valid <= 1'b0;
  endtask

  // outputs checked mid-cycle and acceptance seen before the next edge
  always @(negedge clk) begin : monitor
    logic [68:0] head;
    logic        squash;
    if (rst) begin
      exp_redir = 1'b0;
    end else begin
      assert (redirect_valid == exp_redir)
        else report_mismatch("redirect_valid", 64'(redirect_valid), 64'(exp_redir));
      if (exp_redir) begin
        assert (redirect_pc == exp_redir_pc)
          else report_mismatch("redirect_pc", redirect_pc, exp_redir_pc);
      end
      if (wb_valid) begin
        assert (exp_q.size() > 0) else abort_run("writeback appeared with none expected");
        head = exp_q.pop_front();
        assert (wb_rd == head[68:64])
          else report_mismatch("wb_rd", 64'(wb_rd), 64'(head[68:64]));
        assert (wb_data == head[63:0])
          else report_mismatch("wb_data", wb_data, head[63:0]);
      end
      assert (!i_int_core.i_assert.any_fail)
        else abort_run("a bound protocol assertion failed");
      squash    = exp_redir;
      exp_redir = 1'b0;
      if (in_valid && in_allowin && !squash) begin
        model_step(in_pc, in_inst);
      end
    end
  end

  initial begin
    logic [20:0] off;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    int          waits;
    void'($urandom(32'hfbf3fc92));
    for (int i = 0; i < 32; i++) begin
      mirror[i] = '0;
    end
    rst      = 1'b1;
    in_valid = 1'b0;
    in_pc    = '0;
    in_inst  = '0;
    pc       = 64'h0000_0000_8000_0000;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (in_allowin) else abort_run("in_allowin low after reset");
    @(posedge clk);

    // every register read once before its first write
    for (int r = 1; r < 32; r++) begin
      send(enc_i(op_imm, 3'b000, 5'(r), 5'(r), 12'(r)));
    end

    // lui then a dependent addi per register
    for (int r = 1; r < 8; r++) begin
      send({20'($urandom), 5'(r), op_lui});
      send(enc_i(op_imm, 3'b000, 5'(r), 5'(r), 12'($urandom)));
    end
    send({20'($urandom), 5'd3, op_auipc});
    send({20'($urandom), 5'd0, op_lui});

    repeat (300) send(rand_alu());

    // back-to-back chain on x5
    repeat (12) send(enc_i(op_imm, 3'b000, 5'd5, 5'd5, 12'h001));
    send(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6, op_op_32));

    // each redirect is followed by an instruction that must vanish
    repeat (80) begin
      f3  = 3'($urandom);
      f3  = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
      rs1 = 5'($urandom_range(1, 7));
      rs2 = ($urandom_range(0, 3) == 0) ? rs1 : 5'($urandom_range(1, 7));
      off = 21'($urandom) & ~21'h1;
      send(enc_r({off[12], off[10:5]}, rs2, rs1, f3, {off[4:1], off[11]}, op_branch));
      send(rand_alu());
    end
    repeat (20) begin
      off = 21'($urandom) & ~21'h1;
      send({off[20], off[10:1], off[11], off[19:12], 5'($urandom_range(0, 7)), op_jal});
      send(rand_alu());
      send(enc_i(op_jalr, 3'b000, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                 12'($urandom)));
      send(rand_alu());
    end

    // load and system opcodes are bubbles
    repeat (10) begin
      send({25'($urandom), 7'h03});
      send(rand_alu());
      send({25'($urandom), 7'h73});
    end

    waits = 0;
    while (exp_q.size() != 0 && waits < 50) begin
      @(negedge clk);
      waits++;
    end
    repeat (4) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("expected writebacks never arrived");
    end
  end

endmodule

/* sim/int_core_assert.sv */
`timescale 1ns/1ps
//####################
// protocol checks bound onto the integer core top
//####################
module int_core_assert (
  input logic                            clk,
  input logic                            rst,
  input logic                            in_valid,
  input logic                            in_allowin,
  input logic                            redirect_valid,
  input logic                            wb_valid,
  input logic [core_pkg::reg_addr_w-1:0] wb_rd
);

  logic rd_zero_err  = 1'b0;
  logic reset_err    = 1'b0;
  logic redirect_err = 1'b0;
  logic allowin_err  = 1'b0;
  logic any_fail;

  assign any_fail = rd_zero_err || reset_err || redirect_err || allowin_err;

  // a writeback always names a real register
  assert property (@(posedge clk) disable iff (rst) wb_valid |-> (wb_rd != '0))
    else begin
      rd_zero_err = 1'b1;
      $error("writeback with rd of zero");
    end

  // registers cleared by the first reset edge
  assert property (@(posedge clk) (rst && $past(rst)) |-> (!wb_valid && !redirect_valid))
    else begin
      reset_err = 1'b1;
      $error("output active during reset");
    end

  // the instruction behind a redirect is always dropped
  assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid)
    else begin
      redirect_err = 1'b1;
      $error("redirect in two consecutive cycles");
    end

  // empty decode register and no writeback, nothing to wait for
  assert property (@(posedge clk) disable iff (rst)
                   (!$past(in_valid && in_allowin) && !wb_valid) |-> in_allowin)
    else begin
      allowin_err = 1'b1;
      $error("in_allowin low with no write pending");
    end

endmodule

bind int_core int_core_assert i_assert (
  .clk            (clk),
  .rst            (rst),
  .in_valid       (in_valid),
  .in_allowin     (in_allowin),
  .redirect_valid (redirect_valid),
  .wb_valid       (wb_valid),
  .wb_rd          (wb_rd)
);

/* src/int_core.sv */
`timescale 1ns/1ps
//####################
// integer core top wiring decode, execute and result
//####################
module int_core (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [core_pkg::xlen-1:0]       in_pc,
  input  core_pkg::inst_u                 in_inst,
  output logic                            in_allowin,
  output logic                            redirect_valid,
  output logic [core_pkg::xlen-1:0]       redirect_pc,
  output logic                            wb_valid,
  output logic [core_pkg::reg_addr_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]       wb_data
);
  import core_pkg::*;

  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  issue_if  iss_bus ();
  result_if res_bus ();

  decode_stage i_decode (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_pc          (in_pc),
    .in_inst        (in_inst),
    .in_allowin     (in_allowin),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .redirect_valid (redirect_valid),
    .iss            (iss_bus.source),
    .res            (res_bus.monitor)
  );

  execute_stage i_execute (
    .clk            (clk),
    .rst            (rst),
    .iss            (iss_bus.sink),
    .res            (res_bus.source),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  result_stage i_result (
    .clk      (clk),
    .rst      (rst),
    .res      (res_bus.sink),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

/* src/result_stage.sv */
`timescale 1ns/1ps
//####################
// register file and writeback outputs
//####################
module result_stage (
  input  logic                            clk,
  input  logic                            rst,
  result_if.sink                          res,
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [core_pkg::xlen-1:0]       rs1_data,
  output logic [core_pkg::xlen-1:0]       rs2_data,
  output logic                            wb_valid,
  output logic [core_pkg::reg_addr_w-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]       wb_data
);
  import core_pkg::*;

  // x0 is not stored
  logic [xlen-1:0] regs [1:31];

  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
    logic [xlen-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (res.valid && res.rd == addr) begin
      // write-through of the value landing this cycle
      val = res.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (res.valid) begin
      regs[res.rd] <= res.data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  assign wb_valid = res.valid;
  assign wb_rd    = res.rd;
  assign wb_data  = res.data;

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps
//####################
// ALU, branch resolve and writeback register
//####################
module execute_stage (
  input  logic                      clk,
  input  logic                      rst,
  issue_if.sink                     iss,
  result_if.source                  res,
  output logic                      redirect_valid,
  output logic [core_pkg::xlen-1:0] redirect_pc
);
  import core_pkg::*;

  logic [5:0]      shamt;
  logic [xlen-1:0] alu_d;
  logic [31:0]     alu_w;
  logic [xlen-1:0] alu_res;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  logic            is_jump;
  logic [xlen-1:0] jalr_sum;
  logic [xlen-1:0] wb_data;

  // never stalls
  assign iss.allowin = 1'b1;

  assign shamt = iss.op2[5:0];

  assign eq  = (iss.op1 == iss.op2);
  assign lt  = ($signed(iss.op1) < $signed(iss.op2));
  assign ltu = (iss.op1 < iss.op2);

  always_comb begin
    case (iss.alu_op)
      alu_sub:  alu_d = iss.op1 - iss.op2;
      alu_slt:  alu_d = xlen'(lt);
      alu_sltu: alu_d = xlen'(ltu);
      alu_xor:  alu_d = iss.op1 ^ iss.op2;
      alu_or:   alu_d = iss.op1 | iss.op2;
      alu_and:  alu_d = iss.op1 & iss.op2;
      alu_sll:  alu_d = iss.op1 << shamt;
      alu_srl:  alu_d = iss.op1 >> shamt;
      alu_sra:  alu_d = $signed(iss.op1) >>> shamt;
      default:  alu_d = iss.op1 + iss.op2;
    endcase
  end

  // W forms, low 32 bits with 5-bit shifts
  always_comb begin
    case (iss.alu_op)
      alu_sub: alu_w = iss.op1[31:0] - iss.op2[31:0];
      alu_sll: alu_w = iss.op1[31:0] << shamt[4:0];
      alu_srl: alu_w = iss.op1[31:0] >> shamt[4:0];
      alu_sra: alu_w = $signed(iss.op1[31:0]) >>> shamt[4:0];
      default: alu_w = iss.op1[31:0] + iss.op2[31:0];
    endcase
  end

  assign alu_res = iss.is_word ? {{32{alu_w[31]}}, alu_w} : alu_d;

  always_comb begin
    case (iss.br_op)
      br_beq:           taken = eq;
      br_bne:           taken = !eq;
      br_blt:           taken = lt;
      br_bge:           taken = !lt;
      br_bltu:          taken = ltu;
      br_bgeu:          taken = !ltu;
      br_jal, br_jalr:  taken = 1'b1;
      default:          taken = 1'b0;
    endcase
  end

  assign is_jump  = (iss.br_op == br_jal) || (iss.br_op == br_jalr);
  assign jalr_sum = iss.op1 + iss.jmp_imm;

  assign redirect_valid = iss.valid && taken;
  // jalr target is rs1 + imm with bit 0 cleared
  assign redirect_pc    = (iss.br_op == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0}
                                                 : iss.pc + iss.jmp_imm;

  // link value for jumps
  assign wb_data = is_jump ? iss.pc + xlen'(4) : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= iss.valid && iss.rd_ena && (iss.rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (iss.valid) begin
      res.rd   <= iss.rd;
      res.data <= wb_data;
    end
  end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps
//####################
// instruction decode, operand select and RAW stall
//####################
module decode_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [core_pkg::xlen-1:0]       in_pc,
  input  core_pkg::inst_u                 in_inst,
  output logic                            in_allowin,
  output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [core_pkg::xlen-1:0]       rs1_data,
  input  logic [core_pkg::xlen-1:0]       rs2_data,
  input  logic                            redirect_valid,
  issue_if.source                         iss,
  result_if.monitor                       res
);
  import core_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [11:0]     imm12;
  logic            is_op_imm;
  logic            is_op_imm_32;
  logic            is_op;
  logic            is_op_32;
  logic            is_lui;
  logic            is_auipc;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            legal;
  alu_op_e         alu_op_d;
  br_op_e          br_op_d;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] op1_d;
  logic [xlen-1:0] op2_d;
  logic            use_rs1;
  logic            use_rs2;
  logic            rs1_busy;
  logic            rs2_busy;
  logic            accept;

  assign opcode = in_inst.r.opcode;
  assign funct3 = in_inst.r.funct3;
  assign funct7 = in_inst.r.funct7;
  assign imm12  = in_inst.i.imm12;

  assign is_op_imm    = (opcode == op_imm);
  assign is_op_imm_32 = (opcode == op_imm_32);
  assign is_op        = (opcode == op_op);
  assign is_op_32     = (opcode == op_op_32);
  assign is_lui       = (opcode == op_lui);
  assign is_auipc     = (opcode == op_auipc);
  assign is_branch    = (opcode == op_branch);
  assign is_jal       = (opcode == op_jal);
  assign is_jalr      = (opcode == op_jalr);

  // immediates, S/B/U/J gathered from the r-format fields
  assign imm_i = {{52{imm12[11]}}, imm12};
  assign imm_b = {{52{funct7[6]}}, in_inst.r.rd[0], funct7[5:0], in_inst.r.rd[4:1], 1'b0};
  assign imm_u = {{32{funct7[6]}}, funct7, in_inst.r.rs2, in_inst.r.rs1, funct3, 12'h000};
  assign imm_j = {{44{funct7[6]}}, in_inst.r.rs1, funct3, in_inst.r.rs2[0],
                  funct7[5:0], in_inst.r.rs2[4:1], 1'b0};

  always_comb begin
    // funct7 bit 5 picks sub and sra
    case (funct3)
      3'b000:  alu_op_d = ((is_op || is_op_32) && funct7[5]) ? alu_sub : alu_add;
      3'b001:  alu_op_d = alu_sll;
      3'b010:  alu_op_d = alu_slt;
      3'b011:  alu_op_d = alu_sltu;
      3'b100:  alu_op_d = alu_xor;
      3'b101:  alu_op_d = funct7[5] ? alu_sra : alu_srl;
      3'b110:  alu_op_d = alu_or;
      default: alu_op_d = alu_and;
    endcase
    // lui and auipc add on op1
    if (is_lui || is_auipc) begin
      alu_op_d = alu_add;
    end
  end

  always_comb begin
    legal   = 1'b0;
    br_op_d = br_none;
    case (opcode)
      op_imm: begin
        if (funct3 == 3'b001) begin
          legal = (imm12[11:6] == 6'h00);
        end else if (funct3 == 3'b101) begin
          legal = (imm12[11:6] == 6'h00) || (imm12[11:6] == 6'h10);
        end else begin
          legal = 1'b1;
        end
      end
      op_imm_32: legal = (funct3 == 3'b000) || (funct3 == 3'b001 && funct7 == 7'h00) ||
                         (funct3 == 3'b101 && (funct7 == 7'h00 || funct7 == 7'h20));
      op_op: legal = (funct7 == 7'h00) ||
                     (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      op_op_32: legal = (funct7 == 7'h00 &&
                         (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) ||
                        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      op_lui, op_auipc: legal = 1'b1;
      op_jal: begin
        legal   = 1'b1;
        br_op_d = br_jal;
      end
      op_jalr: begin
        legal   = (funct3 == 3'b000);
        br_op_d = br_jalr;
      end
      op_branch: begin
        legal = (funct3[2:1] != 2'b01);
        case (funct3)
          3'b000:  br_op_d = br_beq;
          3'b001:  br_op_d = br_bne;
          3'b100:  br_op_d = br_blt;
          3'b101:  br_op_d = br_bge;
          3'b110:  br_op_d = br_bltu;
          3'b111:  br_op_d = br_bgeu;
          default: br_op_d = br_none;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // op1 is rs1 for jalr too, the target adds onto it in execute
  always_comb begin
    op1_d = rs1_data;
    if (is_auipc || is_jal) begin
      op1_d = in_pc;
    end else if (is_lui) begin
      op1_d = '0;
    end
    op2_d = imm_i;
    if (is_op || is_op_32 || is_branch) begin
      op2_d = rs2_data;
    end else if (is_lui || is_auipc) begin
      op2_d = imm_u;
    end else if (is_jal || is_jalr) begin
      op2_d = xlen'(4);
    end
  end

  assign rs1_addr = in_inst.r.rs1;
  assign rs2_addr = in_inst.r.rs2;

  assign use_rs1 = is_op_imm || is_op_imm_32 || is_op || is_op_32 || is_branch || is_jalr;
  assign use_rs2 = is_op || is_op_32 || is_branch;

  // pending writes sit in the decode register or the writeback register
  assign rs1_busy = use_rs1 && (rs1_addr != '0) &&
                    ((iss.valid && iss.rd_ena && iss.rd == rs1_addr) ||
                     (res.valid && res.rd == rs1_addr));
  assign rs2_busy = use_rs2 && (rs2_addr != '0) &&
                    ((iss.valid && iss.rd_ena && iss.rd == rs2_addr) ||
                     (res.valid && res.rd == rs2_addr));

  // the younger instruction is dropped on a redirect, no need to hold it
  assign in_allowin = (!iss.valid || iss.allowin) &&
                      (redirect_valid || !(rs1_busy || rs2_busy));
  assign accept     = in_valid && in_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      iss.valid <= 1'b0;
    end else begin
      // unsupported encodings enter as bubbles
      iss.valid <= accept && legal && !redirect_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss.pc      <= in_pc;
      iss.op1     <= op1_d;
      iss.op2     <= op2_d;
      iss.alu_op  <= alu_op_d;
      iss.is_word <= is_op_imm_32 || is_op_32;
      iss.br_op   <= br_op_d;
      iss.jmp_imm <= is_branch ? imm_b : (is_jal ? imm_j : imm_i);
      iss.rd      <= in_inst.r.rd;
      iss.rd_ena  <= !(is_branch || !legal);
    end
  end

endmodule

/* src/result_if.sv */
`timescale 1ns/1ps
//####################
// execute to result, one register writeback
//####################
interface result_if;
  import core_pkg::*;

  // valid only for a real write with rd != 0
  logic                  valid;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       data;

  modport source (output valid, rd, data);

  modport sink (input valid, rd, data);

  // hazard check in decode
  modport monitor (input valid, rd, data);

endinterface

/* src/issue_if.sv */
`timescale 1ns/1ps
//####################
// decode to execute, one decoded instruction
//####################
interface issue_if;
  import core_pkg::*;

  logic                  valid;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       op1;
  logic [xlen-1:0]       op2;
  alu_op_e               alu_op;
  logic                  is_word;
  br_op_e                br_op;
  logic [xlen-1:0]       jmp_imm;
  logic [reg_addr_w-1:0] rd;
  logic                  rd_ena;
  logic                  allowin;

  // decode also reads rd, rd_ena and valid back for the hazard check
  modport source (
    output valid, pc, op1, op2, alu_op, is_word, br_op, jmp_imm, rd, rd_ena,
    input  allowin
  );

  modport sink (
    input  valid, pc, op1, op2, alu_op, is_word, br_op, jmp_imm, rd, rd_ena,
    output allowin
  );

endinterface

/* src/core_pkg.sv */
//####################
// shared widths, opcodes and decode types for the integer core
//####################
package core_pkg;

  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;

  // major opcodes handled by decode
  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_imm_32 = 7'h1b;
  localparam logic [6:0] op_op     = 7'h33;
  localparam logic [6:0] op_op_32  = 7'h3b;
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_auipc  = 7'h17;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_jal    = 7'h6f;
  localparam logic [6:0] op_jalr   = 7'h67;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  // br_none for anything that does not change the pc
  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } br_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // same 32-bit word, register and immediate views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

endpackage
